/* rtl/console_pkg.sv */
// register map decoded on the full 32-bit address with the peripheral at base zero
package console_pkg;

  // bus widths shared by the AXI4-Lite port and the internal register bus
  localparam int unsigned ADDR_W     = 32;
  localparam int unsigned DATA_W     = 32;
  localparam int unsigned DATA_BYTES = DATA_W / 8;
  localparam int unsigned CHAR_W     = 8;

  // each status field is half a data word
  localparam int unsigned STATUS_FIELD_W = 16;

  typedef logic [ADDR_W-1:0]     addr_t;
  typedef logic [DATA_W-1:0]     data_t;
  typedef logic [DATA_BYTES-1:0] strb_t;
  typedef logic [CHAR_W-1:0]     char_t;

  // only the two response codes this slave can produce
  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_slverr = 2'b10
  } resp_t;

  // write-only character register, reads back as zero
  localparam addr_t TXDATA_ADDR = 32'h0000_0000;

  // read-only status, fill level in 15:0 and pending lines in 31:16
  localparam addr_t STATUS_ADDR = 32'h0000_0004;

  // this byte closes a line and releases it to the character port
  localparam char_t NEWLINE_CHAR = 8'h0A;

endpackage

/* rtl/reg_bus_if.sv */
// single-access register bus, the slave must answer in the same cycle as valid
`timescale 1ns/1ps

interface reg_bus_if;

  // request side, driven by the bridge
  logic                valid;
  logic                write;
  console_pkg::addr_t  addr;
  console_pkg::data_t  wdata;
  console_pkg::strb_t  wstrb;

  // response side, driven by the register block
  logic                ready;
  console_pkg::data_t  rdata;
  logic                error;

  // the bridge issues one access at a time and samples the answer on valid and ready
  modport bridge (
    output valid,
    output write,
    output addr,
    output wdata,
    output wstrb,
    input  ready,
    input  rdata,
    input  error
  );

  // the register block answers combinationally
  modport regs (
    input  valid,
    input  write,
    input  addr,
    input  wdata,
    input  wstrb,
    output ready,
    output rdata,
    output error
  );

endinterface

/* rtl/line_buf_if.sv */
// buffer pop port, BUF_DEPTH must be a power of two between 2 and 32768
`timescale 1ns/1ps

interface line_buf_if #(
  parameter int unsigned BUF_DEPTH = 16
);

  // wide enough to hold a fill level of BUF_DEPTH itself
  localparam int unsigned FILL_W = $clog2(BUF_DEPTH) + 1;

  // oldest byte in the buffer, valid while nonempty is high
  console_pkg::char_t head_char;
  logic               nonempty;
  // at least one newline is sitting in the buffer
  logic               line_pending;
  // removes head_char at the next edge
  logic               pop;

  modport regs (
    output head_char,
    output nonempty,
    output line_pending,
    input  pop
  );

  modport drain (
    input  head_char,
    input  nonempty,
    input  line_pending,
    output pop
  );

endinterface

/* rtl/axi_lite_to_reg.sv */
// one outstanding AXI4-Lite transaction, no bursts, IDs or protection, writes win over reads
`timescale 1ns/1ps

module axi_lite_to_reg (
  input  logic                clk_i,
  input  logic                rst_ni,
  // write address channel
  input  logic                awvalid_i,
  output logic                awready_o,
  input  console_pkg::addr_t  awaddr_i,
  // write data channel
  input  logic                wvalid_i,
  output logic                wready_o,
  input  console_pkg::data_t  wdata_i,
  input  console_pkg::strb_t  wstrb_i,
  // write response channel
  output logic                bvalid_o,
  input  logic                bready_i,
  output console_pkg::resp_t  bresp_o,
  // read address channel
  input  logic                arvalid_i,
  output logic                arready_o,
  input  console_pkg::addr_t  araddr_i,
  // read data channel
  output logic                rvalid_o,
  input  logic                rready_i,
  output console_pkg::data_t  rdata_o,
  output console_pkg::resp_t  rresp_o,
  // register bus towards the register block
  reg_bus_if.bridge           bus
);

  // idle covers both waiting for channels and the access cycle itself
  typedef enum logic [1:0] {
    st_idle,
    st_bresp,
    st_rresp
  } state_e;

  state_e              state_q;
  logic                aw_full_q;
  logic                w_full_q;
  logic                ar_full_q;
  console_pkg::addr_t  awaddr_q;
  console_pkg::addr_t  araddr_q;
  console_pkg::data_t  wdata_q;
  console_pkg::strb_t  wstrb_q;
  console_pkg::resp_t  resp_q;
  console_pkg::data_t  rdata_q;
  logic                wr_go;
  logic                rd_go;
  logic                access_done;

  // each address and data slot takes one beat and stays closed until its access is done
  assign awready_o = (state_q == st_idle) && !aw_full_q;
  assign wready_o  = (state_q == st_idle) && !w_full_q;
  assign arready_o = (state_q == st_idle) && !ar_full_q;

  // a complete write always goes before a waiting read
  assign wr_go = (state_q == st_idle) && aw_full_q && w_full_q;
  assign rd_go = (state_q == st_idle) && ar_full_q && !wr_go;

  assign bus.valid = wr_go || rd_go;
  assign bus.write = wr_go;
  assign bus.addr  = wr_go ? awaddr_q : araddr_q;
  assign bus.wdata = wdata_q;
  // strobes are masked on reads so nothing is ever appended by accident
  assign bus.wstrb = wr_go ? wstrb_q : '0;

  assign access_done = bus.valid && bus.ready;

  // the response registers feed both response channels, only one is ever valid
  assign bvalid_o = (state_q == st_bresp);
  assign rvalid_o = (state_q == st_rresp);
  assign bresp_o  = resp_q;
  assign rresp_o  = resp_q;
  assign rdata_o  = rdata_q;

  // slot flags and the transaction state
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q   <= st_idle;
      aw_full_q <= 1'b0;
      w_full_q  <= 1'b0;
      ar_full_q <= 1'b0;
    end else begin
      if (awvalid_i && awready_o) begin
        aw_full_q <= 1'b1;
      end
      if (wvalid_i && wready_o) begin
        w_full_q <= 1'b1;
      end
      if (arvalid_i && arready_o) begin
        ar_full_q <= 1'b1;
      end
      case (state_q)
        st_idle: begin
          // the consumed slots free up as the response phase starts
          if (access_done && wr_go) begin
            aw_full_q <= 1'b0;
            w_full_q  <= 1'b0;
            state_q   <= st_bresp;
          end else if (access_done) begin
            ar_full_q <= 1'b0;
            state_q   <= st_rresp;
          end
        end
        st_bresp: begin
          if (bready_i) begin
            state_q <= st_idle;
          end
        end
        st_rresp: begin
          if (rready_i) begin
            state_q <= st_idle;
          end
        end
        default: begin
          state_q <= st_idle;
        end
      endcase
    end
  end

  // request and response payload
  always_ff @(posedge clk_i) begin
    if (awvalid_i && awready_o) begin
      awaddr_q <= awaddr_i;
    end
    if (wvalid_i && wready_o) begin
      wdata_q <= wdata_i;
      wstrb_q <= wstrb_i;
    end
    if (arvalid_i && arready_o) begin
      araddr_q <= araddr_i;
    end
    // held unchanged while the response waits for its ready
    if (access_done) begin
      resp_q  <= bus.error ? console_pkg::resp_slverr : console_pkg::resp_okay;
      rdata_q <= bus.rdata;
    end
  end

endmodule

/* rtl/console_regs.sv */
// BUF_DEPTH must be a power of two from 2 to 32768, a write that does not fit is refused whole
`timescale 1ns/1ps

module console_regs #(
  parameter int unsigned BUF_DEPTH = 16
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  reg_bus_if.regs  bus,
  line_buf_if.regs buf_port
);

  localparam int unsigned PTR_W  = $clog2(BUF_DEPTH);
  localparam int unsigned FILL_W = buf_port.FILL_W;
  // enough bits to count every lane of one word
  localparam int unsigned CNT_W  = $clog2(console_pkg::DATA_BYTES + 1);

  console_pkg::char_t mem_q [BUF_DEPTH];
  logic [PTR_W-1:0]   wr_ptr_q;
  logic [PTR_W-1:0]   rd_ptr_q;
  logic [FILL_W-1:0]  fill_q;
  logic [FILL_W-1:0]  pending_q;
  logic [FILL_W-1:0]  free_after;
  console_pkg::char_t lane_char [console_pkg::DATA_BYTES];
  logic [PTR_W-1:0]   lane_ptr [console_pkg::DATA_BYTES];
  logic [CNT_W-1:0]   n_strb;
  logic [CNT_W-1:0]   n_nl;
  logic               is_tx;
  logic               is_status;
  logic               fits;
  logic               do_write;
  logic               pop_nl;

  assign is_tx     = (bus.addr == console_pkg::TXDATA_ADDR);
  assign is_status = (bus.addr == console_pkg::STATUS_ADDR);

  // each strobed lane lands in the slot after the strobed lanes below it
  always_comb begin
    n_strb = '0;
    n_nl   = '0;
    for (int i = 0; i < console_pkg::DATA_BYTES; i++) begin
      lane_char[i] = bus.wdata[8*i +: 8];
      lane_ptr[i]  = wr_ptr_q + PTR_W'(n_strb);
      if (bus.wstrb[i]) begin
        n_strb = n_strb + CNT_W'(1);
        if (lane_char[i] == console_pkg::NEWLINE_CHAR) begin
          n_nl = n_nl + CNT_W'(1);
        end
      end
    end
  end

  // a byte popped in this cycle already counts as free space
  assign free_after = FILL_W'(BUF_DEPTH) - fill_q + FILL_W'(buf_port.pop);
  assign fits       = (32'(n_strb) <= 32'(free_after));
  assign do_write   = bus.valid && bus.write && is_tx && fits;

  // every access is answered in its own cycle
  assign bus.ready = 1'b1;

  always_comb begin
    if (bus.write) begin
      // only the character register takes writes, and only if all lanes fit
      bus.error = !(is_tx && fits);
    end else begin
      bus.error = !(is_tx || is_status);
    end
  end

  // Status fields are zero-extended to 16 bits each.
  assign bus.rdata = (!bus.write && is_status) ?
                     {console_pkg::STATUS_FIELD_W'(pending_q),
                      console_pkg::STATUS_FIELD_W'(fill_q)} : '0;

  // buffer storage, several lanes may land in one edge at distinct slots
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < console_pkg::DATA_BYTES; i++) begin
      if (do_write && bus.wstrb[i]) begin
        mem_q[lane_ptr[i]] <= lane_char[i];
      end
    end
  end

  assign buf_port.head_char    = mem_q[rd_ptr_q];
  assign buf_port.nonempty     = (fill_q != '0);
  assign buf_port.line_pending = (pending_q != '0);

  // a popped newline closes one pending line
  assign pop_nl = buf_port.pop && (buf_port.head_char == console_pkg::NEWLINE_CHAR);

  // pointers wrap on their own because the depth is a power of two
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
      fill_q    <= '0;
      pending_q <= '0;
    end else begin
      if (do_write) begin
        wr_ptr_q <= wr_ptr_q + PTR_W'(n_strb);
      end
      if (buf_port.pop) begin
        rd_ptr_q <= rd_ptr_q + PTR_W'(1);
      end
      // push and pop can meet in one edge, both counts take the net change
      fill_q    <= fill_q + (do_write ? FILL_W'(n_strb) : '0) - FILL_W'(buf_port.pop);
      pending_q <= pending_q + (do_write ? FILL_W'(n_nl) : '0) - FILL_W'(pop_nl);
    end
  end

endmodule

/* rtl/console_line_out.sv */
// releases bytes only while a whole line is buffered, one character per accepted cycle
`timescale 1ns/1ps

module console_line_out (
  input  logic                clk_i,
  input  logic                rst_ni,
  line_buf_if.drain           buf_port,
  output logic                char_valid_o,
  output console_pkg::char_t  char_o,
  output logic                line_end_o,
  input  logic                char_ready_i
);

  logic               valid_q;
  console_pkg::char_t char_q;
  logic               end_q;
  logic               load;

  // the output register refills when it is empty or its character leaves this cycle
  assign load = buf_port.line_pending && buf_port.nonempty && (!valid_q || char_ready_i);

  // every load takes the head byte out of the buffer
  assign buf_port.pop = load;

  // valid and the line end marker
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      end_q   <= 1'b0;
    end else if (load) begin
      valid_q <= 1'b1;
      end_q   <= (buf_port.head_char == console_pkg::NEWLINE_CHAR);
    end else if (char_ready_i) begin
      // the last character left and no complete line is waiting
      valid_q <= 1'b0;
      end_q   <= 1'b0;
    end
  end

  // character payload, held while the consumer stalls
  always_ff @(posedge clk_i) begin
    if (load) begin
      char_q <= buf_port.head_char;
    end
  end

  assign char_valid_o = valid_q;
  assign char_o       = char_q;
  assign line_end_o   = end_q;

endmodule

/* rtl/console_top.sv */
// AXI4-Lite console, BUF_DEPTH a power of two from 2 to 32768, base address zero
`timescale 1ns/1ps

module console_top #(
  parameter int unsigned BUF_DEPTH = 16
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  // AXI4-Lite slave
  input  logic                awvalid_i,
  output logic                awready_o,
  input  console_pkg::addr_t  awaddr_i,
  input  logic                wvalid_i,
  output logic                wready_o,
  input  console_pkg::data_t  wdata_i,
  input  console_pkg::strb_t  wstrb_i,
  output logic                bvalid_o,
  input  logic                bready_i,
  output console_pkg::resp_t  bresp_o,
  input  logic                arvalid_i,
  output logic                arready_o,
  input  console_pkg::addr_t  araddr_i,
  output logic                rvalid_o,
  input  logic                rready_i,
  output console_pkg::data_t  rdata_o,
  output console_pkg::resp_t  rresp_o,
  // character stream
  output logic                char_valid_o,
  output console_pkg::char_t  char_o,
  output logic                line_end_o,
  input  logic                char_ready_i
);

  reg_bus_if rbus ();
  line_buf_if #(.BUF_DEPTH(BUF_DEPTH)) lbuf ();

  // decode, AXI beats to single register accesses
  axi_lite_to_reg u_bridge (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .awvalid_i (awvalid_i),
    .awready_o (awready_o),
    .awaddr_i  (awaddr_i),
    .wvalid_i  (wvalid_i),
    .wready_o  (wready_o),
    .wdata_i   (wdata_i),
    .wstrb_i   (wstrb_i),
    .bvalid_o  (bvalid_o),
    .bready_i  (bready_i),
    .bresp_o   (bresp_o),
    .arvalid_i (arvalid_i),
    .arready_o (arready_o),
    .araddr_i  (araddr_i),
    .rvalid_o  (rvalid_o),
    .rready_i  (rready_i),
    .rdata_o   (rdata_o),
    .rresp_o   (rresp_o),
    .bus       (rbus)
  );

  // execute, byte buffer and status
  console_regs #(
    .BUF_DEPTH (BUF_DEPTH)
  ) u_regs (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .bus      (rbus),
    .buf_port (lbuf)
  );

  // result, complete lines out to the character port
  console_line_out u_line_out (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .buf_port     (lbuf),
    .char_valid_o (char_valid_o),
    .char_o       (char_o),
    .line_end_o   (line_end_o),
    .char_ready_i (char_ready_i)
  );

endmodule

/* verif/tb_clock_gen.sv */
// free-running clock, reset held low for RESET_CYCLES rising edges and released just after one
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int unsigned PERIOD_NS    = 20,
  parameter int unsigned RESET_CYCLES = 2
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // release lands 1 ns after an edge like every other driven input
  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1;
    rst_no = 1'b1;
  end

endmodule

/* verif/console_tb.sv */
// trace-driven, needs verif/console_trace.txt relative to the run directory and BUF_DEPTH 16
`timescale 1ns/1ps

module console_tb;

  localparam int unsigned BUF_DEPTH       = 16;
  localparam int unsigned CYCLES_PER_LINE = 200;
  localparam string       TRACE_FILE      = "verif/console_trace.txt";

  logic clk_i;
  logic rst_ni;
  logic awvalid_i, awready_o, wvalid_i, wready_o, bvalid_o, bready_i;
  logic arvalid_i, arready_o, rvalid_o, rready_i;
  logic char_valid_o, line_end_o, char_ready_i;
  console_pkg::addr_t awaddr_i, araddr_i;
  console_pkg::data_t wdata_i, rdata_o;
  console_pkg::strb_t wstrb_i;
  console_pkg::resp_t bresp_o, rresp_o;
  console_pkg::char_t char_o;

  // trace operations in file order
  string              op_q [$];
  int                 ln_q [$];
  console_pkg::addr_t addr_q [$];
  console_pkg::data_t data_q [$];
  console_pkg::strb_t strb_q [$];
  console_pkg::resp_t resp_q [$];
  string              txt_q [$];
  int                 trace_lines = 0;
  logic               trace_ready = 1'b0;
  // lines declared by the trace and not yet seen at the character port
  string              exp_text [$];
  int                 exp_ln [$];
  int                 char_idx = 0;
  logic               hold_char = 1'b0;

  tb_clock_gen #(.PERIOD_NS(20), .RESET_CYCLES(2)) u_clk (.clk_o(clk_i), .rst_no(rst_ni));

  console_top #(.BUF_DEPTH(BUF_DEPTH)) dut0 (.*);

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic check_resp(input string name, input console_pkg::resp_t exp_v,
                            input console_pkg::resp_t act_v);
    if (exp_v !== act_v) begin
      fail_run($sformatf("Error: %s expected resp %h actual resp %h", name, exp_v, act_v));
    end
  endtask

  task automatic check_data(input string name, input console_pkg::data_t exp_v,
                            input console_pkg::data_t act_v);
    if (exp_v !== act_v) begin
      fail_run($sformatf("Error: %s expected data %h actual data %h", name, exp_v, act_v));
    end
  endtask

  task automatic check_char(input string name, input console_pkg::char_t exp_c,
                            input logic exp_e, input console_pkg::char_t act_c,
                            input logic act_e);
    if (exp_c !== act_c || exp_e !== act_e) begin
      fail_run($sformatf("Error: %s expected char %h end %b actual char %h end %b",
                         name, exp_c, exp_e, act_c, act_e));
    end
  endtask

  // reads the whole trace up front so the watchdog knows its length
  task automatic load_trace();
    int                 fd;
    int                 n;
    int                 want;
    string              line;
    string              op;
    string              txt;
    console_pkg::addr_t a;
    console_pkg::data_t d;
    console_pkg::strb_t s;
    logic [1:0]         r;
    fd = $fopen(TRACE_FILE, "r");
    if (fd == 0) begin
      fail_run($sformatf("could not open the trace file %s", TRACE_FILE));
    end else begin
      n = $fgets(line, fd);
      while (n != 0) begin
        trace_lines++;
        op = "";
        n = $sscanf(line, "%s", op);
        // blank lines and lines starting with # carry no operation
        if (n == 1 && op.len() > 0 && op[0] != "#") begin
          a = '0;
          d = '0;
          s = '0;
          r = '0;
          txt = "";
          case (op)
            "W": begin
              n = $sscanf(line, "%s %h %h %h %h", op, a, d, s, r);
              want = 5;
            end
            "R": begin
              n = $sscanf(line, "%s %h %h %h", op, a, d, r);
              want = 4;
            end
            "L": begin
              n = $sscanf(line, "%s %s", op, txt);
              want = 2;
            end
            "C": begin
              n = $sscanf(line, "%s %h", op, d);
              want = 2;
            end
            default: want = 1;
          endcase
          if (n < want) begin
            fail_run($sformatf("trace line %0d has too few fields", trace_lines));
          end
          op_q.push_back(op);
          ln_q.push_back(trace_lines);
          addr_q.push_back(a);
          data_q.push_back(d);
          strb_q.push_back(s);
          resp_q.push_back(console_pkg::resp_t'(r));
          txt_q.push_back(txt);
        end
        n = $fgets(line, fd);
      end
      $fclose(fd);
    end
  endtask

  // AW and W go out together, each valid drops after its own handshake
  task automatic axi_write(input string name, input console_pkg::addr_t a,
                           input console_pkg::data_t d, input console_pkg::strb_t s,
                           output console_pkg::resp_t resp);
    logic               aw_done;
    logic               w_done;
    logic               seen;
    console_pkg::resp_t first;
    aw_done = 1'b0;
    w_done = 1'b0;
    seen = 1'b0;
    first = console_pkg::resp_okay;
    awvalid_i = 1'b1;
    awaddr_i = a;
    wvalid_i = 1'b1;
    wdata_i = d;
    wstrb_i = s;
    while (!(aw_done && w_done)) begin
      @(posedge clk_i);
      if (awready_o) aw_done = 1'b1;
      if (wready_o) w_done = 1'b1;
      #1;
      if (aw_done) awvalid_i = 1'b0;
      if (w_done) wvalid_i = 1'b0;
    end
    // the response must not move while bready is low
    do begin
      @(posedge clk_i);
      if (bvalid_o && !seen) begin
        seen = 1'b1;
        first = bresp_o;
      end
    end while (!(bvalid_o && bready_i));
    resp = bresp_o;
    #1;
    check_resp({name, " held bresp"}, first, resp);
  endtask

  task automatic axi_read(input string name, input console_pkg::addr_t a,
                          output console_pkg::data_t data, output console_pkg::resp_t resp);
    logic               seen;
    console_pkg::data_t first;
    console_pkg::resp_t first_resp;
    seen = 1'b0;
    first = '0;
    first_resp = console_pkg::resp_okay;
    arvalid_i = 1'b1;
    araddr_i = a;
    do @(posedge clk_i); while (!arready_o);
    #1;
    arvalid_i = 1'b0;
    do begin
      @(posedge clk_i);
      if (rvalid_o && !seen) begin
        seen = 1'b1;
        first = rdata_o;
        first_resp = rresp_o;
      end
    end while (!(rvalid_o && rready_i));
    data = rdata_o;
    resp = rresp_o;
    #1;
    check_data({name, " held rdata"}, first, data);
    check_resp({name, " held rresp"}, first_resp, resp);
  endtask

  // one transferred character against the oldest declared line
  task automatic take_char(input console_pkg::char_t c, input logic e);
    string              txt;
    console_pkg::char_t exp_c;
    logic               exp_e;
    if (exp_text.size() == 0) begin
      fail_run($sformatf("character %h left the port while no line was expected", c));
    end else begin
      txt = exp_text[0];
      if (char_idx < txt.len()) begin
        exp_c = console_pkg::char_t'(txt[char_idx]);
        exp_e = 1'b0;
      end else begin
        exp_c = console_pkg::NEWLINE_CHAR;
        exp_e = 1'b1;
      end
      check_char($sformatf("trace line %0d char %0d", exp_ln[0], char_idx), exp_c, exp_e, c, e);
      if (e) begin
        void'(exp_text.pop_front());
        void'(exp_ln.pop_front());
        char_idx = 0;
      end else begin
        char_idx++;
      end
    end
  endtask

  // outputs are flop driven, so the pre-edge values are the transferred ones
  always @(posedge clk_i) begin
    if (rst_ni && char_valid_o && char_ready_i) begin
      take_char(char_o, line_end_o);
    end
  end

  // ready back-pressure lands 2 ns after the edge, after the drivers have run
  initial begin
    bready_i = 1'b0;
    rready_i = 1'b0;
    char_ready_i = 1'b0;
    void'($urandom(32'hcb505467));
    forever begin
      @(posedge clk_i);
      #2;
      bready_i = ($urandom % 4) != 0;
      rready_i = ($urandom % 4) != 0;
      char_ready_i = hold_char ? 1'b0 : (($urandom % 4) != 0);
    end
  end

  initial begin
    wait (trace_ready);
    repeat (trace_lines * CYCLES_PER_LINE) @(posedge clk_i);
    fail_run($sformatf("the run hung, it did not finish within %0d cycles",
                       trace_lines * CYCLES_PER_LINE));
  end

  initial begin : run_trace
    console_pkg::resp_t got_resp;
    console_pkg::data_t got_data;
    string              name;
    awvalid_i = 1'b0;
    awaddr_i = '0;
    wvalid_i = 1'b0;
    wdata_i = '0;
    wstrb_i = '0;
    arvalid_i = 1'b0;
    araddr_i = '0;
    load_trace();
    trace_ready = 1'b1;
    wait (rst_ni === 1'b1);
    @(posedge clk_i);
    #1;
    for (int i = 0; i < op_q.size(); i++) begin
      name = $sformatf("trace line %0d %s", ln_q[i], op_q[i]);
      case (op_q[i])
        "W": begin
          axi_write(name, addr_q[i], data_q[i], strb_q[i], got_resp);
          check_resp(name, resp_q[i], got_resp);
        end
        "R": begin
          axi_read(name, addr_q[i], got_data, got_resp);
          check_data(name, data_q[i], got_data);
          check_resp(name, resp_q[i], got_resp);
        end
        "L": begin
          exp_text.push_back(txt_q[i]);
          exp_ln.push_back(ln_q[i]);
        end
        "C": hold_char = (data_q[i] == '0);
        "D": begin
          while (exp_text.size() != 0) begin
            @(posedge clk_i);
            #1;
          end
        end
        default: fail_run($sformatf("trace line %0d has an unknown operation", ln_q[i]));
      endcase
    end
    // idle a while so a stray partial line would show up at the port
    repeat (20) @(posedge clk_i);
    #1;
    if (exp_text.size() != 0) begin
      fail_run($sformatf("%0d expected lines never reached the character port",
                         exp_text.size()));
    end else begin
      $display("Test OK");
      $finish;
    end
  end

endmodule

/* console_top.f */
rtl/console_pkg.sv
rtl/reg_bus_if.sv
rtl/line_buf_if.sv
rtl/axi_lite_to_reg.sv
rtl/console_regs.sv
rtl/console_line_out.sv
rtl/console_top.sv
verif/tb_clock_gen.sv
verif/console_tb.sv

/* run.sh */
#!/bin/sh
# build the console testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module console_tb \
  -f console_top.f -Mdir obj_dir -o console_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/console_sim 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Test OK"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1

/* verif/console_trace.txt */
# W addr data strb resp | R addr data resp | L text, newline implied | all numbers hex
# C 0 holds char_ready low, C 1 lets it toggle | D waits until every declared line is out
C 1
L Hi
W 0 00000048 1 0
W 0 00000069 1 0
W 0 0000000A 1 0
L ABC
W 0 0A434241 F 0
L ED
W 0 44FF4500 A 0
W 0 0000000A 1 0
D
C 0
R 4 00000000 0
L XXXXYYYYZZZZabc
W 0 58585858 F 0
W 0 59595959 F 0
W 0 5A5A5A5A F 0
W 0 00636261 7 0
R 4 0000000F 0
W 0 00004847 3 2
R 4 0000000F 0
W 0 0000000A 1 0
R 4 0001000F 0
C 1
D
W 4 12345678 F 2
W 8 00000041 1 2
R 8 00000000 2
R 0 00000000 0
R 4 00000000 0
W 0 00006B6F 3 0
R 4 00000002 0
